/* verilog/pcieSubPkg.sv */
package pcieSubPkg;

   // Bus widths
   localparam int addrWidth = 64;
   localparam int dataWidth = 128;

   // Host ring addresses
   localparam logic [addrWidth-1:0] ptrAddr        = 64'h10;
   localparam logic [addrWidth-1:0] nextRegionAddr = 64'h0;
   localparam logic [addrWidth-1:0] initNextPtr    = 64'h1000;

   // Region field of the ring pointer
   localparam int regionLsb  = 12;
   localparam int lastRegion = 7;
   localparam int regionBits = $clog2(lastRegion + 1);

   // Block layout
   localparam int entryStride  = 16;
   localparam int blockWords   = 16;
   localparam int ramAddrWidth = 4;

   localparam int pollBits = 6;

   // AXI codes
   localparam logic [2:0] axiSizeBeat  = 3'd4;
   localparam logic [1:0] axiBurstIncr = 2'd1;
   localparam logic [2:0] axiProtVal   = 3'd2;
   localparam logic [1:0] respOkay     = 2'd0;

   // Shared by AR and AW
   typedef struct packed {
      logic [addrWidth-1:0] addr;
      logic [3:0]           id;
      logic [7:0]           len;
      logic [2:0]           size;
      logic [1:0]           burst;
      logic [2:0]           prot;
   } axiAddrT;

   typedef struct packed {
      logic [dataWidth-1:0]   data;
      logic [dataWidth/8-1:0] strb;
      logic                   last;
   } axiWDataT;

   typedef struct packed {
      logic [dataWidth-1:0] data;
      logic [3:0]           id;
      logic [1:0]           resp;
      logic                 last;
   } axiRDataT;

   typedef struct packed {
      logic [3:0] id;
      logic [1:0] resp;
   } axiBRespT;

   // Internal request and response pulses
   typedef struct packed {
      logic                 valid;
      logic [addrWidth-1:0] addr;
   } rdReqT;

   typedef struct packed {
      logic                 valid;
      logic [addrWidth-1:0] addr;
      logic [dataWidth-1:0] data;
   } wrReqT;

   typedef struct packed {
      logic                 done;
      logic [dataWidth-1:0] data;
      logic                 err;
   } rdRspT;

   typedef struct packed {
      logic done;
      logic err;
   } wrRspT;

endpackage

/* verilog/axiReadMaster.sv */
`timescale 1ns/100ps

module axiReadMaster (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pcieSubPkg::rdReqT    rdReq,
   output pcieSubPkg::rdRspT    rdRsp,
   output pcieSubPkg::axiAddrT  ar,
   output logic                 arValid,
   input  logic                 arReady,
   input  pcieSubPkg::axiRDataT r,
   input  logic                 rValid,
   output logic                 rReady
);
   import pcieSubPkg::*;

   typedef enum logic [1:0] {
      stIdle,
      stAddr,
      stData
   } rdStateT;

   rdStateT              state;
   logic [addrWidth-1:0] addrReg;
   logic [dataWidth-1:0] dataReg;
   logic                 errReg;
   logic                 doneReg;

   // Request address and returned beat
   always_ff @(posedge clk) begin
      if (state == stIdle && rdReq.valid) begin
         addrReg <= rdReq.addr;
      end
      if (state == stData && rValid && rReady) begin
         dataReg <= r.data;
         errReg  <= (r.resp != respOkay);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= stIdle;
         arValid <= 1'b0;
         rReady  <= 1'b0;
         doneReg <= 1'b0;
      end else begin
         doneReg <= 1'b0;
         case (state)
            stIdle: begin
               if (rdReq.valid) begin
                  arValid <= 1'b1;
                  state   <= stAddr;
               end
            end
            stAddr: begin
               // Hold AR until accepted
               if (arReady) begin
                  arValid <= 1'b0;
                  rReady  <= 1'b1;
                  state   <= stData;
               end
            end
            stData: begin
               if (rValid) begin
                  rReady  <= 1'b0;
                  doneReg <= 1'b1;
                  state   <= stIdle;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Single beat, INCR, 16 bytes
   assign ar = '{addr: addrReg, id: '0, len: '0, size: axiSizeBeat,
                 burst: axiBurstIncr, prot: axiProtVal};

   assign rdRsp = '{done: doneReg, data: dataReg, err: errReg};

endmodule

/* verilog/axiWriteMaster.sv */
`timescale 1ns/100ps

module axiWriteMaster (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pcieSubPkg::wrReqT    wrReq,
   output pcieSubPkg::wrRspT    wrRsp,
   output pcieSubPkg::axiAddrT  aw,
   output logic                 awValid,
   input  logic                 awReady,
   output pcieSubPkg::axiWDataT w,
   output logic                 wValid,
   input  logic                 wReady,
   input  pcieSubPkg::axiBRespT b,
   input  logic                 bValid,
   output logic                 bReady
);
   import pcieSubPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stBoth,
      stAddrOnly,
      stDataOnly,
      stResp
   } wrStateT;

   wrStateT              state;
   logic [addrWidth-1:0] addrReg;
   logic [dataWidth-1:0] dataReg;
   logic                 errReg;
   logic                 doneReg;

   always_ff @(posedge clk) begin
      if (state == stIdle && wrReq.valid) begin
         addrReg <= wrReq.addr;
         dataReg <= wrReq.data;
      end
      if (state == stResp && bValid && bReady) begin
         errReg <= (b.resp != respOkay);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= stIdle;
         awValid <= 1'b0;
         wValid  <= 1'b0;
         bReady  <= 1'b0;
         doneReg <= 1'b0;
      end else begin
         doneReg <= 1'b0;
         case (state)
            stIdle: begin
               if (wrReq.valid) begin
                  awValid <= 1'b1;
                  wValid  <= 1'b1;
                  state   <= stBoth;
               end
            end
            stBoth: begin
               // Keep whichever channel is still pending
               case ({awReady, wReady})
                  2'b11: begin
                     awValid <= 1'b0;
                     wValid  <= 1'b0;
                     bReady  <= 1'b1;
                     state   <= stResp;
                  end
                  2'b10: begin
                     awValid <= 1'b0;
                     state   <= stDataOnly;
                  end
                  2'b01: begin
                     wValid <= 1'b0;
                     state  <= stAddrOnly;
                  end
                  default: begin
                     state <= stBoth;
                  end
               endcase
            end
            stAddrOnly: begin
               if (awReady) begin
                  awValid <= 1'b0;
                  bReady  <= 1'b1;
                  state   <= stResp;
               end
            end
            stDataOnly: begin
               if (wReady) begin
                  wValid <= 1'b0;
                  bReady <= 1'b1;
                  state  <= stResp;
               end
            end
            stResp: begin
               if (bValid) begin
                  bReady  <= 1'b0;
                  doneReg <= 1'b1;
                  state   <= stIdle;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   assign aw = '{addr: addrReg, id: '0, len: '0, size: axiSizeBeat,
                 burst: axiBurstIncr, prot: axiProtVal};

   // Full-width single beat
   assign w = '{data: dataReg, strb: '1, last: 1'b1};

   assign wrRsp = '{done: doneReg, err: errReg};

endmodule

/* verilog/ringFetchCtrl.sv */
`timescale 1ns/100ps

module ringFetchCtrl (
   input  logic                                clk,
   input  logic                                rst_n,
   output pcieSubPkg::rdReqT                   rdReq,
   input  pcieSubPkg::rdRspT                   rdRsp,
   output pcieSubPkg::wrReqT                   wrReq,
   input  pcieSubPkg::wrRspT                   wrRsp,
   output logic                                ramWrEn,
   output logic [pcieSubPkg::ramAddrWidth-1:0] ramWrAddr,
   output logic [pcieSubPkg::dataWidth-1:0]    ramWrData,
   output logic                                ibDataValid,
   input  logic                                ibDone
);
   import pcieSubPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stPtrLoad,
      stFetch,
      stPtrUpdate,
      stWaitConsumer
   } fetchStateT;

   fetchStateT              state;
   logic [pollBits-1:0]     pollCnt;
   logic [addrWidth-1:0]    nextPtr;
   logic [ramAddrWidth-1:0] entryCnt;
   logic                    rdValid;
   logic                    wrValid;
   logic [regionBits-1:0]   curRegion;
   logic [regionBits-1:0]   hostRegion;
   logic [regionBits-1:0]   advRegion;
   logic [addrWidth-1:0]    newBase;
   logic [addrWidth-1:0]    fetchAddr;
   logic                    lastEntry;

   assign curRegion  = nextPtr[regionLsb +: regionBits];
   assign hostRegion = rdRsp.data[regionLsb +: regionBits];

   // Region index wraps after the last one
   assign advRegion = (curRegion == regionBits'(lastRegion)) ? '0 : curRegion + 1'b1;
   assign newBase   = addrWidth'(advRegion) << regionLsb;

   // Entry k sits at base + 16*k
   assign fetchAddr = nextPtr + addrWidth'(entryCnt) * addrWidth'(entryStride);
   assign lastEntry = (entryCnt == ramAddrWidth'(blockWords - 1));

   assign rdReq = '{valid: rdValid, addr: (state == stPtrLoad) ? ptrAddr : fetchAddr};
   assign wrReq = '{valid: wrValid, addr: nextRegionAddr, data: dataWidth'(newBase)};

   assign ramWrEn   = (state == stFetch) && rdRsp.done && !rdRsp.err;
   assign ramWrAddr = entryCnt;
   assign ramWrData = rdRsp.data;

   // Free-running poll timer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pollCnt <= '0;
      end else begin
         pollCnt <= pollCnt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= stIdle;
         rdValid     <= 1'b0;
         wrValid     <= 1'b0;
         nextPtr     <= initNextPtr;
         entryCnt    <= '0;
         ibDataValid <= 1'b0;
      end else begin
         rdValid <= 1'b0;
         wrValid <= 1'b0;
         case (state)
            stIdle: begin
               if (pollCnt == '1) begin
                  rdValid <= 1'b1;
                  state   <= stPtrLoad;
               end
            end
            stPtrLoad: begin
               if (rdRsp.done) begin
                  if (rdRsp.err) begin
                     rdValid <= 1'b1;
                  end else if (hostRegion != curRegion) begin
                     entryCnt <= '0;
                     rdValid  <= 1'b1;
                     state    <= stFetch;
                  end else begin
                     state <= stIdle;
                  end
               end
            end
            stFetch: begin
               if (rdRsp.done) begin
                  if (rdRsp.err) begin
                     // Same entry again
                     rdValid <= 1'b1;
                  end else if (lastEntry) begin
                     wrValid <= 1'b1;
                     state   <= stPtrUpdate;
                  end else begin
                     entryCnt <= entryCnt + 1'b1;
                     rdValid  <= 1'b1;
                  end
               end
            end
            stPtrUpdate: begin
               if (wrRsp.done) begin
                  if (wrRsp.err) begin
                     wrValid <= 1'b1;
                  end else begin
                     nextPtr     <= newBase;
                     ibDataValid <= 1'b1;
                     state       <= stWaitConsumer;
                  end
               end
            end
            stWaitConsumer: begin
               if (ibDone) begin
                  ibDataValid <= 1'b0;
                  state       <= stIdle;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

endmodule

/* verilog/inboundRam.sv */
`timescale 1ns/100ps

module inboundRam (
   input  logic                                clk,
   input  logic                                wrEn,
   input  logic [pcieSubPkg::ramAddrWidth-1:0] wrAddr,
   input  logic [pcieSubPkg::dataWidth-1:0]    wrData,
   input  logic                                rdEn,
   input  logic [pcieSubPkg::ramAddrWidth-1:0] rdAddr,
   output logic [pcieSubPkg::dataWidth-1:0]    rdData
);
   import pcieSubPkg::*;

   logic [dataWidth-1:0] mem [blockWords];

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

   // Registered read, one cycle after rdEn
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

/* verilog/pcieSubTop.sv */
`timescale 1ns/100ps

module pcieSubTop (
   input  logic                                clk,
   input  logic                                rst_n,
   output pcieSubPkg::axiAddrT                 ar,
   output logic                                arValid,
   input  logic                                arReady,
   input  pcieSubPkg::axiRDataT                r,
   input  logic                                rValid,
   output logic                                rReady,
   output pcieSubPkg::axiAddrT                 aw,
   output logic                                awValid,
   input  logic                                awReady,
   output pcieSubPkg::axiWDataT                w,
   output logic                                wValid,
   input  logic                                wReady,
   input  pcieSubPkg::axiBRespT                b,
   input  logic                                bValid,
   output logic                                bReady,
   input  logic                                ibRdEn,
   input  logic [pcieSubPkg::ramAddrWidth-1:0] ibRdAddr,
   output logic [pcieSubPkg::dataWidth-1:0]    ibRdData,
   output logic                                ibDataValid,
   input  logic                                ibDone
);
   import pcieSubPkg::*;

   rdReqT                   rdReq;
   rdRspT                   rdRsp;
   wrReqT                   wrReq;
   wrRspT                   wrRsp;
   logic                    ramWrEn;
   logic [ramAddrWidth-1:0] ramWrAddr;
   logic [dataWidth-1:0]    ramWrData;

   ringFetchCtrl ringFetchCtrl_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .rdReq       (rdReq),
      .rdRsp       (rdRsp),
      .wrReq       (wrReq),
      .wrRsp       (wrRsp),
      .ramWrEn     (ramWrEn),
      .ramWrAddr   (ramWrAddr),
      .ramWrData   (ramWrData),
      .ibDataValid (ibDataValid),
      .ibDone      (ibDone)
   );

   axiReadMaster axiReadMaster_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rdReq   (rdReq),
      .rdRsp   (rdRsp),
      .ar      (ar),
      .arValid (arValid),
      .arReady (arReady),
      .r       (r),
      .rValid  (rValid),
      .rReady  (rReady)
   );

   axiWriteMaster axiWriteMaster_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .wrReq   (wrReq),
      .wrRsp   (wrRsp),
      .aw      (aw),
      .awValid (awValid),
      .awReady (awReady),
      .w       (w),
      .wValid  (wValid),
      .wReady  (wReady),
      .b       (b),
      .bValid  (bValid),
      .bReady  (bReady)
   );

   inboundRam inboundRam_i (
      .clk    (clk),
      .wrEn   (ramWrEn),
      .wrAddr (ramWrAddr),
      .wrData (ramWrData),
      .rdEn   (ibRdEn),
      .rdAddr (ibRdAddr),
      .rdData (ibRdData)
   );

endmodule

/* test/axiBus_props.sv */
`timescale 1ns/100ps

module axiBusProps (
   input logic                 clk,
   input logic                 rst_n,
   input pcieSubPkg::axiAddrT  ar,
   input logic                 arValid,
   input logic                 arReady,
   input pcieSubPkg::axiAddrT  aw,
   input logic                 awValid,
   input logic                 awReady,
   input pcieSubPkg::axiWDataT w,
   input logic                 wValid,
   input logic                 wReady,
   input logic                 rReady,
   input logic                 bReady,
   input logic                 ibDataValid,
   input pcieSubPkg::rdReqT    rdReq,
   input pcieSubPkg::rdRspT    rdRsp,
   input pcieSubPkg::wrReqT    wrReq,
   input pcieSubPkg::wrRspT    wrRsp
);

   // Count of failed assertions
   int failCount = 0;

   // Valid holds with a stable payload until ready
   arHold: assert property (@(posedge clk) disable iff (!rst_n)
      (arValid && !arReady) |=> (arValid && $stable(ar)))
      else begin
         failCount++;
         $error("AR valid dropped or payload changed before ready");
      end

   awHold: assert property (@(posedge clk) disable iff (!rst_n)
      (awValid && !awReady) |=> (awValid && $stable(aw)))
      else begin
         failCount++;
         $error("AW valid dropped or payload changed before ready");
      end

   wHold: assert property (@(posedge clk) disable iff (!rst_n)
      (wValid && !wReady) |=> (wValid && $stable(w)))
      else begin
         failCount++;
         $error("W valid dropped or payload changed before ready");
      end

   // State right out of reset
   resetQuiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !(arValid || awValid || wValid || rReady || bReady || ibDataValid
                         || rdReq.valid || wrReq.valid || rdRsp.done || wrRsp.done))
      else begin
         failCount++;
         $error("Bus or request outputs not low after reset");
      end

endmodule

bind pcieSubTop axiBusProps axiBusProps_i (.*);

/* test/pcieSubTb.sv */
`timescale 1ns/100ps

module pcieSubTb;
   import pcieSubPkg::*;

   localparam int clkPeriod    = 20;
   localparam int driveDelay   = 2;
   localparam int fetchTimeout = 4000;
   localparam int pollTimeout  = 300;
   localparam int numRows      = 11;

   typedef struct packed {
      logic [2:0] hostRegion;
      logic       ptrErr;
      logic       entryErr;
      logic [3:0] errIdx;
      logic       wrErr;
      logic       expFetch;
      logic [2:0] expWrRegion;
   } rowT;

   // hostRegion, ptrErr, entryErr, errIdx, wrErr, expFetch, expWrRegion
   localparam rowT scenarios [numRows] = '{
      '{3'd0, 1'b0, 1'b0, 4'd0,  1'b0, 1'b1, 3'd2},
      '{3'd2, 1'b0, 1'b0, 4'd0,  1'b0, 1'b0, 3'd0},
      '{3'd5, 1'b1, 1'b0, 4'd0,  1'b0, 1'b1, 3'd3},
      '{3'd5, 1'b0, 1'b1, 4'd7,  1'b0, 1'b1, 3'd4},
      '{3'd5, 1'b0, 1'b0, 4'd0,  1'b1, 1'b1, 3'd5},
      '{3'd5, 1'b0, 1'b0, 4'd0,  1'b0, 1'b0, 3'd0},
      '{3'd0, 1'b0, 1'b0, 4'd0,  1'b0, 1'b1, 3'd6},
      '{3'd0, 1'b0, 1'b0, 4'd0,  1'b0, 1'b1, 3'd7},
      '{3'd3, 1'b0, 1'b0, 4'd0,  1'b0, 1'b1, 3'd0},
      '{3'd0, 1'b0, 1'b0, 4'd0,  1'b0, 1'b0, 3'd0},
      '{3'd3, 1'b1, 1'b1, 4'd15, 1'b1, 1'b1, 3'd1}
   };

   logic                    clk;
   logic                    rst_n;
   axiAddrT                 ar;
   logic                    arValid;
   logic                    arReady = 1'b0;
   axiRDataT                r = '0;
   logic                    rValid = 1'b0;
   logic                    rReady;
   axiAddrT                 aw;
   logic                    awValid;
   logic                    awReady = 1'b0;
   axiWDataT                w;
   logic                    wValid;
   logic                    wReady = 1'b0;
   axiBRespT                b = '0;
   logic                    bValid = 1'b0;
   logic                    bReady;
   logic                    ibRdEn;
   logic [ramAddrWidth-1:0] ibRdAddr;
   logic [dataWidth-1:0]    ibRdData;
   logic                    ibDataValid;
   logic                    ibDone;

   // Host memory model and transaction logs
   logic [dataWidth-1:0] mem [logic [addrWidth-1:0]];
   logic [addrWidth-1:0] arLog [$];
   logic [addrWidth-1:0] awLog [$];
   logic [dataWidth-1:0] wrLog [$];
   logic [dataWidth-1:0] expData [blockWords];
   logic [addrWidth-1:0] expAr [$];
   logic [31:0]          lfsr = 32'ha704_71a0;
   int                   curRow = 0;
   logic [addrWidth-1:0] rowBase = '0;
   int                   ptrDoneCnt = 0;
   int                   ptrErrRow = -1;
   int                   entryErrRow = -1;
   int                   wrErrRow = -1;
   logic                 rBusy = 1'b0;
   logic                 rIsPtr = 1'b0;
   logic [dataWidth-1:0] rDataHold = '0;
   logic [1:0]           rRespHold = '0;
   logic                 awPend = 1'b0;
   logic                 wPend = 1'b0;
   logic                 bBusy = 1'b0;
   logic [1:0]           bRespHold = '0;

   pcieSubTop pcieSubTop_i (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Galois LFSR stepped once per bit
   function automatic logic takeBit();
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
      return lfsr[0];
   endfunction

   task automatic abortRun();
      $display("TEST FAIL");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic reportMismatch(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      abortRun();
   endtask

   task automatic reportTimeout(input string msg);
      $display("Timeout: %s", msg);
      abortRun();
   endtask

   task automatic fillHostMemory();
      logic [dataWidth-1:0] word;
      for (int rg = 0; rg <= lastRegion; rg++) begin
         for (int k = 0; k < blockWords; k++) begin
            for (int i = 0; i < dataWidth; i++) begin
               word[i] = takeBit();
            end
            mem[(addrWidth'(rg) << regionLsb) + addrWidth'(k) * addrWidth'(entryStride)] = word;
         end
      end
   endtask

   // AXI slave with random ready and valid delays
   always @(posedge clk) begin : slaveModel
      logic                 active;
      logic                 rFire;
      logic                 bFire;
      logic [addrWidth-1:0] errAddr;
      active  = rst_n;
      rFire   = rValid && rReady;
      bFire   = bValid && bReady;
      errAddr = rowBase + addrWidth'(scenarios[curRow].errIdx) * addrWidth'(entryStride);
      if (active) begin
         // Ready only between the request handshake and the response
         assert (rReady == rBusy) else reportMismatch("rReady outside the R response window");
         assert (bReady == bBusy) else reportMismatch("bReady outside the B response window");
         if (rFire) begin
            rBusy = 1'b0;
            if (rIsPtr && r.resp == respOkay) begin
               ptrDoneCnt++;
            end
         end
         if (arValid && arReady) begin
            assert (ar.len == '0 && ar.size == axiSizeBeat && ar.burst == axiBurstIncr
                    && ar.prot == axiProtVal)
               else reportMismatch("AR is not a single 16-byte INCR beat");
            arLog.push_back(ar.addr);
            rBusy     = 1'b1;
            rIsPtr    = (ar.addr == ptrAddr);
            rDataHold = mem.exists(ar.addr) ? mem[ar.addr] : '0;
            rRespHold = respOkay;
            if (rIsPtr && scenarios[curRow].ptrErr && ptrErrRow != curRow) begin
               ptrErrRow = curRow;
               rRespHold = 2'd2;
               rDataHold = ~rDataHold;
            end else if (!rIsPtr && scenarios[curRow].entryErr && ar.addr == errAddr
                         && entryErrRow != curRow) begin
               entryErrRow = curRow;
               rRespHold   = 2'd2;
               rDataHold   = ~rDataHold;
            end
         end
         if (bFire) begin
            bBusy = 1'b0;
         end
         if (awValid && awReady) begin
            assert (aw.len == '0 && aw.size == axiSizeBeat && aw.burst == axiBurstIncr
                    && aw.prot == axiProtVal)
               else reportMismatch("AW is not a single 16-byte INCR beat");
            awPend = 1'b1;
            awLog.push_back(aw.addr);
         end
         if (wValid && wReady) begin
            assert (w.strb == '1 && w.last) else reportMismatch("W beat without full strobe");
            wPend = 1'b1;
            wrLog.push_back(w.data);
         end
         if (awPend && wPend && !bBusy) begin
            awPend    = 1'b0;
            wPend     = 1'b0;
            bBusy     = 1'b1;
            bRespHold = respOkay;
            if (scenarios[curRow].wrErr && wrErrRow != curRow) begin
               wrErrRow  = curRow;
               bRespHold = 2'd2;
            end else begin
               mem[awLog[$]] = wrLog[$];
            end
         end
      end
      #(driveDelay);
      if (active) begin
         arReady = takeBit();
         awReady = takeBit();
         wReady  = takeBit();
         if (rFire) begin
            rValid = 1'b0;
         end
         if (bFire) begin
            bValid = 1'b0;
         end
         if (rBusy && !rValid && takeBit()) begin
            r      = '{data: rDataHold, id: '0, resp: rRespHold, last: 1'b1};
            rValid = 1'b1;
         end
         if (bBusy && !bValid && takeBit()) begin
            b      = '{id: '0, resp: bRespHold};
            bValid = 1'b1;
         end
      end
   end

   task automatic waitDataValid();
      int n;
      for (n = 0; n < fetchTimeout; n++) begin
         @(posedge clk);
         #(driveDelay);
         if (ibDataValid) break;
      end
      assert (n < fetchTimeout) else reportTimeout("ibDataValid never rose during a fetch");
   endtask

   // Waits for poll events while nothing else may happen
   task automatic watchQuiet(input int arTarget, input int ptrTarget, input int awStart);
      int n;
      for (n = 0; n < pollTimeout; n++) begin
         @(posedge clk);
         #(driveDelay);
         assert (!ibDataValid) else reportMismatch("ibDataValid rose with the pointer unchanged");
         assert (awLog.size() == awStart) else reportMismatch("write issued without a fetch");
         if (arLog.size() >= arTarget && ptrDoneCnt >= ptrTarget) break;
      end
      assert (n < pollTimeout) else reportTimeout("no pointer poll seen on the read channel");
   endtask

   task automatic checkFetch(input int row, input int arStart, input int awStart);
      logic [dataWidth-1:0] expWr;
      expWr = dataWidth'(scenarios[row].expWrRegion) << regionLsb;
      expAr.delete();
      expAr.push_back(ptrAddr);
      if (scenarios[row].ptrErr) expAr.push_back(ptrAddr);
      for (int k = 0; k < blockWords; k++) begin
         expAr.push_back(rowBase + addrWidth'(k) * addrWidth'(entryStride));
         if (scenarios[row].entryErr && scenarios[row].errIdx == k) begin
            expAr.push_back(expAr[$]);
         end
      end
      assert (arLog.size() - arStart == expAr.size())
         else reportMismatch($sformatf("row %0d: %0d reads, expected %0d",
                                       row, arLog.size() - arStart, expAr.size()));
      for (int i = 0; i < expAr.size(); i++) begin
         assert (arLog[arStart + i] == expAr[i])
            else reportMismatch($sformatf("row %0d: read %0d at %h, expected %h",
                                          row, i, arLog[arStart + i], expAr[i]));
      end
      assert (awLog.size() - awStart == 1 + int'(scenarios[row].wrErr))
         else reportMismatch($sformatf("row %0d: wrong number of writes", row));
      for (int i = awStart; i < awLog.size(); i++) begin
         assert (awLog[i] == nextRegionAddr && wrLog[i] == expWr)
            else reportMismatch($sformatf("row %0d: write %h to %h, expected %h",
                                          row, wrLog[i], awLog[i], expWr));
      end
      assert (mem[nextRegionAddr] == expWr)
         else reportMismatch($sformatf("row %0d: host word 0x0 holds %h", row, mem[nextRegionAddr]));
      for (int k = 0; k < blockWords; k++) begin
         ibRdEn   = 1'b1;
         ibRdAddr = ramAddrWidth'(k);
         @(posedge clk);
         #(driveDelay);
         assert (ibRdData == expData[k])
            else reportMismatch($sformatf("row %0d: RAM[%0d] = %h, expected %h",
                                          row, k, ibRdData, expData[k]));
      end
      ibRdEn = 1'b0;
      assert (ibDataValid) else reportMismatch("ibDataValid fell before ibDone");
      ibDone = 1'b1;
      @(posedge clk);
      #(driveDelay);
      ibDone = 1'b0;
      assert (!ibDataValid) else reportMismatch("ibDataValid still high after ibDone");
   endtask

   initial begin : mainFlow
      int expRegion;
      int arStart;
      int awStart;
      int ptrStart;
      rst_n    = 1'b1;
      ibRdEn   = 1'b0;
      ibRdAddr = '0;
      ibDone   = 1'b0;
      fillHostMemory();
      #1;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #(driveDelay);
      rst_n     = 1'b1;
      expRegion = 1;
      for (int row = 0; row < numRows; row++) begin
         curRow  = row;
         rowBase = addrWidth'(expRegion) << regionLsb;
         mem[ptrAddr] = dataWidth'(scenarios[row].hostRegion) << regionLsb;
         // Block as the host holds it before the fetch
         for (int k = 0; k < blockWords; k++) begin
            expData[k] = mem[rowBase + addrWidth'(k) * addrWidth'(entryStride)];
         end
         arStart  = arLog.size();
         awStart  = awLog.size();
         ptrStart = ptrDoneCnt;
         if (scenarios[row].expFetch) begin
            waitDataValid();
            checkFetch(row, arStart, awStart);
            expRegion = int'(scenarios[row].expWrRegion);
         end else begin
            watchQuiet(arStart + 1, ptrStart + 1, awStart);
            watchQuiet(arStart + 2, ptrStart + 1, awStart);
            watchQuiet(arStart + 2, ptrStart + 2, awStart);
            assert (arLog.size() == arStart + 2 && arLog[arStart] == ptrAddr
                    && arLog[arStart + 1] == ptrAddr)
               else reportMismatch($sformatf("row %0d: entry read without a pointer change", row));
         end
      end
      if (pcieSubTop_i.axiBusProps_i.failCount != 0) begin
         $display("Bound AXI bus assertions failed %0d times",
                  pcieSubTop_i.axiBusProps_i.failCount);
         abortRun();
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

/* pcieSub.f */
verilog/pcieSubPkg.sv
verilog/axiReadMaster.sv
verilog/axiWriteMaster.sv
verilog/ringFetchCtrl.sv
verilog/inboundRam.sv
verilog/pcieSubTop.sv
test/axiBus_props.sv
test/pcieSubTb.sv

/* Makefile */
# Verilator simulation of the ring fetch engine

VERILATOR ?= verilator
TOP       ?= pcieSubTb
FILELIST  ?= pcieSub.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
